// ==== vlog.f ====
+incdir+source
source/tl_output_pkg.sv
source/mmio_access_decode.sv
source/output_register.sv
source/tl_slave_ctrl.sv
source/tl_output_top.sv
tb/tb_clock_gen.sv
tb/tl_output_assertions.sv
tb/tl_output_tb.sv

// ==== Bender.yml ====
package:
  name: tl_output

export_include_dirs:
  - source

sources:
  - source/tl_output_pkg.sv
  - source/mmio_access_decode.sv
  - source/output_register.sv
  - source/tl_slave_ctrl.sv
  - source/tl_output_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tl_output_assertions.sv
      - tb/tl_output_tb.sv

// ==== tb/tl_output_tb.sv ====
// Directed testbench for the TL-UL output register slave
// LFSR stimulus, register model, typed compare tasks, watchdog

`timescale 1ns/100ps

`include "tl_output_defs.svh"

module tl_output_tb import tl_output_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 40;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;

    logic                   clk;
    logic                   reset;
    logic [`TL_OUTPUTS-1:0] outputs;
    logic                   tl_a_valid, tl_a_ready;
    tl_a_opcode_e           tl_a_opcode;
    tl_size_e               tl_a_size, tl_d_size;
    tl_source_t             tl_a_source, tl_d_source;
    tl_data_t               tl_a_address, tl_a_data, tl_d_data;
    tl_mask_t               tl_a_mask;
    logic                   tl_d_valid, tl_d_ready, tl_d_denied;
    tl_d_opcode_e           tl_d_opcode;

    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    int          cycle_count = 0;
    logic [15:0] lfsr_state  = 16'd15;
    tl_data_t    model_value = '0;  // Expected register contents

    tb_clock_gen clock_gen_inst (.clk, .reset);

    tl_output_top tl_output_top_inst (.*);

    bind tl_slave_ctrl tl_output_assertions assertions_inst (.*);

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus source, register model, compare tasks
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic tl_data_t random_bits(input int count);
        tl_data_t bits;
        int       i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    // Narrow writes take the low data bits
    task automatic model_write(input tl_size_e size, input byte_offset_t off, input tl_data_t d);
        case (size)
            SIZE_BYTE: model_value[8*off +: 8] = d[7:0];
            SIZE_HALF: model_value[16*off[1] +: 16] = d[15:0];
            default:   model_value = d;
        endcase
    endtask

    function automatic tl_data_t model_read(input tl_size_e size, input byte_offset_t off);
        case (size)
            SIZE_BYTE: return tl_data_t'(model_value[8*off +: 8]);       // Zero-extended
            SIZE_HALF: return tl_data_t'(model_value[16*off[1] +: 16]);
            default:   return model_value;
        endcase
    endfunction

    task automatic report_check(input logic ok, input string name, input tl_data_t got,
                                input tl_data_t exp);
        check_count++;
        if (!ok) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_data(input string name, input tl_data_t got, input tl_data_t exp);
        report_check(got === exp, name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        report_check(got === exp, name, tl_data_t'(got), tl_data_t'(exp));
    endtask

    task automatic check_opcode(input string name, input tl_d_opcode_e got,
                                input tl_d_opcode_e exp);
        report_check(got === exp, name, tl_data_t'(got), tl_data_t'(exp));
    endtask

    task automatic check_source(input string name, input tl_source_t got, input tl_source_t exp);
        report_check(got === exp, name, tl_data_t'(got), tl_data_t'(exp));
    endtask

    task automatic check_size(input string name, input tl_size_e got, input tl_size_e exp);
        report_check(got === exp, name, tl_data_t'(got), tl_data_t'(exp));
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("%-18s %s", name, (error_count == errors_before) ? "ok" : "errors found");
    endtask

    //////////////////////////////////////////////////////////////////////
    // One TL-UL transaction with D-channel stall
    //////////////////////////////////////////////////////////////////////

    task automatic access(input tl_a_opcode_e op, input tl_size_e size, input tl_data_t addr,
                          input tl_mask_t mask, input tl_data_t data, input int stall,
                          input tl_d_opcode_e exp_op, input tl_data_t exp_data,
                          input logic exp_denied);
        tl_data_t   rnd;
        tl_source_t src;
        logic       accept_now;
        int         latency;
        int         i;
        rnd          = random_bits(2);
        src          = rnd[1:0];
        tl_a_opcode  = op;
        tl_a_size    = size;
        tl_a_source  = src;
        tl_a_address = addr;
        tl_a_mask    = mask;
        tl_a_data    = data;
        tl_a_valid   = 1'b1;
        accept_now   = 1'b0;
        while (!accept_now) begin
            accept_now = tl_a_ready;  // Accepted on the coming edge
            @(posedge clk);
            #1;
        end
        tl_a_valid = 1'b0;
        latency    = 0;
        while (!tl_d_valid) begin
            @(posedge clk);
            #1;
            latency++;
        end
        check_data("tl_d_valid latency", tl_data_t'(latency), 32'd2);
        for (i = 0; i <= stall; i++) begin
            // First pass checks the response and later passes check that it holds
            check_bit("tl_d_valid", tl_d_valid, 1'b1);
            check_bit("tl_a_ready", tl_a_ready, 1'b0);
            check_opcode("tl_d_opcode", tl_d_opcode, exp_op);
            check_data("tl_d_data", tl_d_data, exp_data);
            check_bit("tl_d_denied", tl_d_denied, exp_denied);
            check_source("tl_d_source", tl_d_source, src);
            check_size("tl_d_size", tl_d_size, size);
            if (i < stall) begin
                @(posedge clk);
                #1;
            end
        end
        tl_d_ready = 1'b1;
        @(posedge clk);  // Handshake
        #1;
        tl_d_ready = 1'b0;
        check_bit("tl_d_valid", tl_d_valid, 1'b0);
        check_bit("tl_a_ready", tl_a_ready, 1'b0);
        @(posedge clk);
        #1;
        check_bit("tl_a_ready", tl_a_ready, 1'b1);  // Back one edge after handshake
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset;
        int errors_before;
        errors_before = error_count;
        @(negedge reset);
        check_bit("tl_a_ready", tl_a_ready, 1'b0);
        check_bit("tl_d_valid", tl_d_valid, 1'b0);
        check_data("outputs", tl_data_t'(outputs), '0);
        @(posedge clk);
        #1;
        check_bit("tl_a_ready", tl_a_ready, 1'b1);
        report_test("reset", errors_before);
    endtask

    task automatic test_word_access;
        int       errors_before;
        tl_data_t data;
        errors_before = error_count;
        data = random_bits(32);
        access(PUT_FULL_DATA, SIZE_WORD, '0, 4'hF, data, 0, ACCESS_ACK, '0, 1'b0);
        model_write(SIZE_WORD, 2'd0, data);
        check_data("outputs", tl_data_t'(outputs), model_read(SIZE_BYTE, 2'd0));
        access(GET, SIZE_WORD, '0, 4'hF, '0, 0, ACCESS_ACK_DATA, data, 1'b0);
        report_test("word_access", errors_before);
    endtask

    task automatic test_partial_writes;
        int       errors_before;
        int       k;
        tl_data_t data;
        errors_before = error_count;
        for (k = 0; k < 4; k++) begin
            data = random_bits(32);
            access(PUT_PARTIAL_DATA, SIZE_BYTE, tl_data_t'(k), tl_mask_t'(4'b0001 << k), data,
                   0, ACCESS_ACK, '0, 1'b0);
            model_write(SIZE_BYTE, byte_offset_t'(k), data);
            check_data("outputs", tl_data_t'(outputs), model_read(SIZE_BYTE, 2'd0));
            // Whole word shows which lane took the byte
            access(GET, SIZE_WORD, '0, 4'hF, '0, 0, ACCESS_ACK_DATA, model_value, 1'b0);
        end
        for (k = 0; k < 4; k += 2) begin
            data = random_bits(32);
            access(PUT_PARTIAL_DATA, SIZE_HALF, tl_data_t'(k), (k == 0) ? 4'b0011 : 4'b1100,
                   data, 0, ACCESS_ACK, '0, 1'b0);
            model_write(SIZE_HALF, byte_offset_t'(k), data);
            check_data("outputs", tl_data_t'(outputs), model_read(SIZE_BYTE, 2'd0));
            access(GET, SIZE_WORD, '0, 4'hF, '0, 0, ACCESS_ACK_DATA, model_value, 1'b0);
        end
        report_test("partial_writes", errors_before);
    endtask

    task automatic test_partial_reads;
        int errors_before;
        int k;
        errors_before = error_count;
        for (k = 0; k < 4; k++) begin
            access(GET, SIZE_BYTE, tl_data_t'(k), tl_mask_t'(4'b0001 << k), '0, 0,
                   ACCESS_ACK_DATA, model_read(SIZE_BYTE, byte_offset_t'(k)), 1'b0);
        end
        access(GET, SIZE_HALF, 32'd0, 4'b0011, '0, 0, ACCESS_ACK_DATA,
               model_read(SIZE_HALF, 2'd0), 1'b0);
        access(GET, SIZE_HALF, 32'd2, 4'b1100, '0, 0, ACCESS_ACK_DATA,
               model_read(SIZE_HALF, 2'd2), 1'b0);
        access(GET, SIZE_WORD, '0, 4'hF, '0, 0, ACCESS_ACK_DATA, model_value, 1'b0);
        report_test("partial_reads", errors_before);
    endtask

    // Denied requests must leave the register alone
    task automatic test_illegal;
        int errors_before;
        errors_before = error_count;
        access(PUT_PARTIAL_DATA, SIZE_BYTE, '0, 4'b0011, random_bits(32), 0, ACCESS_ACK, '0, 1'b1);
        access(PUT_PARTIAL_DATA, SIZE_HALF, '0, 4'b0110, random_bits(32), 0, ACCESS_ACK, '0, 1'b1);
        access(PUT_FULL_DATA, SIZE_WORD, '0, 4'b0111, random_bits(32), 0, ACCESS_ACK, '0, 1'b1);
        access(GET, tl_size_e'(3'd3), '0, 4'hF, '0, 0, ACCESS_ACK_DATA, '0, 1'b1);
        access(tl_a_opcode_e'(3'd2), SIZE_WORD, '0, 4'hF, random_bits(32), 0,
               ACCESS_ACK, '0, 1'b1);  // Arithmetic op is unsupported
        access(GET, SIZE_WORD, '0, 4'hF, '0, 0, ACCESS_ACK_DATA, model_value, 1'b0);
        check_data("outputs", tl_data_t'(outputs), model_read(SIZE_BYTE, 2'd0));
        report_test("illegal_accesses", errors_before);
    endtask

    task automatic test_back_pressure;
        int       errors_before;
        int       n;
        tl_data_t data;
        errors_before = error_count;
        for (n = 0; n < 3; n++) begin
            data = random_bits(32);
            access(PUT_FULL_DATA, SIZE_WORD, '0, 4'hF, data, int'(random_bits(3)),
                   ACCESS_ACK, '0, 1'b0);
            model_write(SIZE_WORD, 2'd0, data);
            access(GET, SIZE_WORD, '0, 4'hF, '0, int'(random_bits(3)),
                   ACCESS_ACK_DATA, model_value, 1'b0);
        end
        report_test("back_pressure", errors_before);
    endtask

    initial begin
        tl_a_valid   = 1'b0;
        tl_a_opcode  = PUT_FULL_DATA;
        tl_a_size    = SIZE_WORD;
        tl_a_source  = '0;
        tl_a_address = '0;
        tl_a_mask    = '0;
        tl_a_data    = '0;
        tl_d_ready   = 1'b0;
        test_reset();
        test_word_access();
        test_partial_writes();
        test_partial_reads();
        test_illegal();
        test_back_pressure();
        // Bound protocol assertions count as errors too
        error_count += tl_output_top_inst.slave_ctrl_inst.assertions_inst.fail_count;
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/tl_output_assertions.sv ====
// Concurrent TL-UL checks bound into the slave controller
// Reset state, D-channel hold under back-pressure, response latency

`timescale 1ns/100ps

module tl_output_assertions import tl_output_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         tl_a_valid,
    input logic         tl_a_ready,
    input logic         tl_d_valid,
    input logic         tl_d_ready,
    input tl_d_opcode_e tl_d_opcode,
    input tl_size_e     tl_d_size,
    input tl_source_t   tl_d_source,
    input tl_data_t     tl_d_data,
    input logic         tl_d_denied
);

    int fail_count = 0;  // Failed assertions so far

    // D channel quiet right after reset release
    reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !tl_d_valid && !tl_d_denied)
        else begin
            fail_count++;
            $error("D channel not idle after reset");
        end

    // Stalled response must not move
    d_hold: assert property (@(posedge clk) disable iff (reset)
        tl_d_valid && !tl_d_ready |=> tl_d_valid && $stable(tl_d_opcode) && $stable(tl_d_size)
            && $stable(tl_d_source) && $stable(tl_d_data) && $stable(tl_d_denied))
        else begin
            fail_count++;
            $error("D fields changed while the response was stalled");
        end

    // Valid is set on the second edge after accept
    d_latency: assert property (@(posedge clk) disable iff (reset)
        tl_a_valid && tl_a_ready |=> !tl_d_valid ##1 !tl_d_valid ##1 tl_d_valid)
        else begin
            fail_count++;
            $error("tl_d_valid not raised 2 cycles after accept");
        end

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source
// 8 ns clock, reset held for the first 4 rising edges

`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;  // Released just after the edge
    end

endmodule

// ==== source/tl_output_top.sv ====
// Top level of the TL-UL output register slave
// Controller, access decoder and register, low bits driven to outputs

`timescale 1ns/100ps

`include "tl_output_defs.svh"

module tl_output_top import tl_output_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`TL_OUTPUTS-1:0] outputs,
    // A channel
    input  logic                   tl_a_valid,
    output logic                   tl_a_ready,
    input  tl_a_opcode_e           tl_a_opcode,
    input  tl_size_e               tl_a_size,
    input  tl_source_t             tl_a_source,
    input  tl_data_t               tl_a_address,
    input  tl_mask_t               tl_a_mask,
    input  tl_data_t               tl_a_data,
    // D channel
    output logic                   tl_d_valid,
    input  logic                   tl_d_ready,
    output tl_d_opcode_e           tl_d_opcode,
    output tl_size_e               tl_d_size,
    output tl_source_t             tl_d_source,
    output tl_data_t               tl_d_data,
    output logic                   tl_d_denied
);

    // Captured request
    tl_a_opcode_e req_opcode;
    tl_size_e     req_size;
    tl_data_t     req_address;
    tl_mask_t     req_mask;
    tl_data_t     req_wdata;

    // Decode results
    logic         access_ok;
    logic         is_read;
    tl_mask_t     byte_lanes;
    byte_offset_t lane_offset;

    logic         write_en;
    tl_data_t     read_data;
    tl_data_t     reg_value;

    tl_slave_ctrl slave_ctrl_inst (
        .clk, .reset,
        .tl_a_valid, .tl_a_ready, .tl_a_opcode, .tl_a_size,
        .tl_a_source, .tl_a_address, .tl_a_mask, .tl_a_data,
        .tl_d_valid, .tl_d_ready, .tl_d_opcode, .tl_d_size,
        .tl_d_source, .tl_d_data, .tl_d_denied,
        .req_opcode, .req_size, .req_address, .req_mask, .req_wdata,
        .access_ok, .is_read, .read_data, .write_en
    );

    mmio_access_decode access_decode_inst (
        .req_opcode, .req_size, .req_address, .req_mask,
        .access_ok, .is_read, .byte_lanes, .lane_offset
    );

    output_register output_register_inst (
        .clk, .reset,
        .write_en, .byte_lanes, .lane_offset, .req_wdata,
        .read_data,
        .value (reg_value)
    );

    assign outputs = reg_value[`TL_OUTPUTS-1:0];  // Pins see the low byte

endmodule

// ==== source/tl_slave_ctrl.sv ====
// TL-UL slave controller
// A/D handshake FSM, request capture and registered response

`timescale 1ns/100ps

module tl_slave_ctrl import tl_output_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    // A channel
    input  logic         tl_a_valid,
    output logic         tl_a_ready,
    input  tl_a_opcode_e tl_a_opcode,
    input  tl_size_e     tl_a_size,
    input  tl_source_t   tl_a_source,
    input  tl_data_t     tl_a_address,
    input  tl_mask_t     tl_a_mask,
    input  tl_data_t     tl_a_data,
    // D channel
    output logic         tl_d_valid,
    input  logic         tl_d_ready,
    output tl_d_opcode_e tl_d_opcode,
    output tl_size_e     tl_d_size,
    output tl_source_t   tl_d_source,
    output tl_data_t     tl_d_data,
    output logic         tl_d_denied,
    // Request to decoder and register
    output tl_a_opcode_e req_opcode,
    output tl_size_e     req_size,
    output tl_data_t     req_address,
    output tl_mask_t     req_mask,
    output tl_data_t     req_wdata,
    // Decode and read results
    input  logic         access_ok,
    input  logic         is_read,
    input  tl_data_t     read_data,
    output logic         write_en
);

    slave_state_e state;
    tl_source_t   req_source;

    // Response formed in PROCESS, presented in RESPOND
    tl_d_opcode_e resp_opcode;
    tl_data_t     resp_data;
    logic         resp_denied;

    logic         a_fire;
    logic         d_fire;

    assign a_fire = tl_a_valid && tl_a_ready;
    assign d_fire = tl_d_valid && tl_d_ready;

    // Single-cycle strobe, only legal writes touch the register
    assign write_en = (state == PROCESS) && access_ok && !is_read;

    //////////////////////////////////////////////////////////////////////
    // Request capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (a_fire) begin
            req_opcode  <= tl_a_opcode;
            req_size    <= tl_a_size;
            req_source  <= tl_a_source;
            req_address <= tl_a_address;
            req_mask    <= tl_a_mask;
            req_wdata   <= tl_a_data;
        end
    end

    // Response latch
    always_ff @(posedge clk) begin
        if (state == PROCESS) begin
            resp_opcode <= is_read ? ACCESS_ACK_DATA : ACCESS_ACK;
            resp_data   <= (access_ok && is_read) ? read_data : '0;  // Zero unless good read
            resp_denied <= !access_ok;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM and D-channel registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            tl_a_ready  <= 1'b0;
            tl_d_valid  <= 1'b0;
            tl_d_opcode <= ACCESS_ACK;
            tl_d_size   <= SIZE_BYTE;
            tl_d_source <= '0;
            tl_d_data   <= '0;
            tl_d_denied <= 1'b0;
        end else begin
            // Ready follows IDLE a cycle late, drops on accept
            tl_a_ready <= (state == IDLE) && !a_fire;

            case (state)
                IDLE: begin
                    if (a_fire) begin
                        state <= PROCESS;
                    end
                end

                PROCESS: begin
                    state <= RESPOND;  // Write lands this edge
                end

                RESPOND: begin
                    tl_d_valid  <= 1'b1;
                    tl_d_opcode <= resp_opcode;
                    tl_d_size   <= req_size;    // Echo
                    tl_d_source <= req_source;  // Echo
                    tl_d_data   <= resp_data;
                    tl_d_denied <= resp_denied;
                    state       <= RESPOND_WAIT;
                end

                RESPOND_WAIT: begin
                    // Hold everything until the host takes it
                    if (d_fire) begin
                        tl_d_valid  <= 1'b0;
                        tl_d_opcode <= ACCESS_ACK;
                        tl_d_size   <= SIZE_BYTE;
                        tl_d_source <= '0;
                        tl_d_data   <= '0;
                        tl_d_denied <= 1'b0;
                        state       <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== source/output_register.sv ====
// The 32-bit output register
// Lane-wise write merge and aligned, zero-extended read

`timescale 1ns/100ps

module output_register import tl_output_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         write_en,
    input  tl_mask_t     byte_lanes,
    input  byte_offset_t lane_offset,
    input  tl_data_t     req_wdata,
    output tl_data_t     read_data,
    output tl_data_t     value
);

    tl_data_t wdata_aligned;  // Write data moved up to its lanes
    tl_data_t value_shifted;  // Register moved down to bit 0
    tl_mask_t keep_lanes;

    assign wdata_aligned = req_wdata << {lane_offset, 3'b000};
    assign value_shifted = value >> {lane_offset, 3'b000};
    assign keep_lanes    = byte_lanes >> lane_offset;

    //////////////////////////////////////////////////////////////////////
    // Register and write merge
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            value <= '0;
        end else if (write_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_lanes[i]) begin
                    value[8*i +: 8] <= wdata_aligned[8*i +: 8];
                end
            end
        end
    end

    // Read extract, unselected bytes forced to zero
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            read_data[8*i +: 8] = keep_lanes[i] ? value_shifted[8*i +: 8] : 8'h00;
        end
    end

endmodule

// ==== source/mmio_access_decode.sv ====
// Legality check and lane selection for a captured TL-UL request
// Combinational, 32-bit bus only

`timescale 1ns/100ps

module mmio_access_decode import tl_output_pkg::*; (
    input  tl_a_opcode_e req_opcode,
    input  tl_size_e     req_size,
    input  tl_data_t     req_address,
    input  tl_mask_t     req_mask,
    output logic         access_ok,
    output logic         is_read,
    output tl_mask_t     byte_lanes,
    output byte_offset_t lane_offset
);

    logic         opcode_ok;
    logic         size_ok;
    logic         mask_ok;
    byte_offset_t addr_lo;

    assign addr_lo = req_address[1:0];  // Register is one word wide
    assign is_read = (req_opcode == GET);

    always_comb begin
        case (req_opcode)
            GET, PUT_FULL_DATA, PUT_PARTIAL_DATA: opcode_ok = 1'b1;
            default:                              opcode_ok = 1'b0;
        endcase
    end

    // Lanes come from the address, the mask is only checked
    always_comb begin
        size_ok     = 1'b1;
        mask_ok     = 1'b0;
        byte_lanes  = 4'b0000;
        lane_offset = 2'd0;
        case (req_size)
            SIZE_BYTE: begin
                byte_lanes  = 4'b0001 << addr_lo;
                lane_offset = addr_lo;
                mask_ok     = ($countones(req_mask) == 1);  // Exactly one strobe
            end
            SIZE_HALF: begin
                byte_lanes  = addr_lo[1] ? 4'b1100 : 4'b0011;
                lane_offset = {addr_lo[1], 1'b0};
                mask_ok     = (req_mask == 4'b0011) || (req_mask == 4'b1100);
            end
            SIZE_WORD: begin
                byte_lanes = 4'b1111;
                mask_ok    = (req_mask == 4'b1111);
            end
            default: begin
                size_ok = 1'b0;  // Double-word and up
            end
        endcase
    end

    // Reads ignore the mask
    assign access_ok = opcode_ok && size_ok && (is_read || mask_ok);

endmodule

// ==== source/tl_output_pkg.sv ====
// Types shared by the TL-UL output slave
// Opcodes, sizes, FSM states and bus field types

package tl_output_pkg;

`include "tl_output_defs.svh"

    // A-channel opcodes
    typedef enum logic [2:0] {
        PUT_FULL_DATA    = 3'd0,
        PUT_PARTIAL_DATA = 3'd1,
        GET              = 3'd4
    } tl_a_opcode_e;

    // D-channel opcodes, denial is flagged separately
    typedef enum logic [2:0] {
        ACCESS_ACK      = 3'd0,
        ACCESS_ACK_DATA = 3'd1
    } tl_d_opcode_e;

    // log2 of the byte count; codes 3 and up are illegal here
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } tl_size_e;

    typedef enum logic [1:0] {IDLE, PROCESS, RESPOND, RESPOND_WAIT} slave_state_e;

    typedef logic [`TL_XLEN-1:0]       tl_data_t;      // Data and address
    typedef logic [`TL_MASK_WIDTH-1:0] tl_mask_t;
    typedef logic [`TL_SID_WIDTH-1:0]  tl_source_t;
    typedef logic [1:0]                byte_offset_t;  // Byte within word

endpackage

// ==== source/tl_output_defs.svh ====
// Width macros for the TL-UL output register slave
// Bus width fixed at 32 bits, no double-word support

`ifndef TL_OUTPUT_DEFS_SVH
`define TL_OUTPUT_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

`define TL_XLEN        32  // Data and address width
`define TL_MASK_WIDTH  4   // One mask bit per byte lane
`define TL_SID_WIDTH   2   // Source ID width

//////////////////////////////////////////////////////////////////////
// Pins
//////////////////////////////////////////////////////////////////////

// Low register bits exposed on the outputs port
`define TL_OUTPUTS     8

`endif
